// File: verilog/decodePkg.sv
`default_nettype none

package decodePkg;

  localparam int INSTR_W = 32;

  localparam logic [3:0] COND_ALWAYS = 4'hE;
  localparam logic [3:0] COND_NEVER  = 4'hF; // reserved in A32

  // ALU operation codes, shared by both ISAs
  typedef enum logic [4:0] {
    ALU_ADD   = 5'b00000,
    ALU_SUB   = 5'b00001,
    ALU_AND   = 5'b00010,
    ALU_OR    = 5'b00011,
    ALU_XOR   = 5'b00100,
    ALU_SLT   = 5'b00101,
    ALU_LUI   = 5'b00110, // pass operand b
    ALU_SLL   = 5'b01000,
    ALU_SRL   = 5'b01001,
    ALU_SRA   = 5'b01010,
    ALU_BIC   = 5'b10000,
    ALU_MOV   = 5'b10001, // shifted operand 2 straight through
    ALU_ADC   = 5'b10010,
    ALU_SBC   = 5'b10011,
    ALU_RSB   = 5'b10100,
    ALU_RSC   = 5'b10110,
    ALU_MVN   = 5'b10111,
    ALU_PASSA = 5'b11111  // base address unchanged
  } aluCtrlE;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_OPREG  = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_OPIMM  = 7'b0010011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111
  } rvOpE;

  // A32 op field, instr[27:25]
  typedef enum logic [2:0] {
    CLS_DPREG  = 3'b000,
    CLS_DPIMM  = 3'b001,
    CLS_MEMIMM = 3'b010,
    CLS_MEMREG = 3'b011,
    CLS_BLOCK  = 3'b100,
    CLS_BRANCH = 3'b101
  } armClassE;

  typedef enum logic [2:0] {
    IMM_I     = 3'b000,
    IMM_S     = 3'b001,
    IMM_B     = 3'b010,
    IMM_J     = 3'b011,
    ARM_IMM8  = 3'b100, // rotated imm8 of data processing
    ARM_IMM12 = 3'b101,
    ARM_IMM24 = 3'b110,
    IMM_U     = 3'b111
  } immSrcE;

  typedef enum logic [1:0] {
    RES_ALU     = 2'b00,
    RES_MEM     = 2'b01,
    RES_PCPLUS4 = 2'b10
  } resultSrcE;

  typedef enum logic [1:0] {
    LDM_FIRST = 2'b00, // transfer, fetch held
    LDM_LAST  = 2'b01  // base writeback
  } ldmPhaseE;

  typedef enum logic [1:0] {
    HS_IDLE = 2'b00,
    HS_HOLD = 2'b01
  } hsStateE;

endpackage

`default_nettype wire

// File: verilog/rvDecoder.sv
`default_nettype none

module rvDecoder (
  input  logic [decodePkg::INSTR_W-1:0] instr,
  output logic                          rvLegal,
  output logic                          regWrite,
  output logic                          memWrite,
  output logic [1:0]                    memSize,
  output logic                          memSigned,
  output decodePkg::aluCtrlE            aluControl,
  output logic [1:0]                    branch,
  output logic [1:0]                    aluSrc,
  output decodePkg::immSrcE             immSrc,
  output decodePkg::resultSrcE          resultSrc,
  output logic [3:0]                    cond
);

  import decodePkg::*;

  rvOpE       op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [1:0] aluOp;     // 00 add, 01 compare, 10 funct decode, 11 lui
  logic       mainLegal;
  logic       aluLegal;
  logic       condLegal;

  assign op      = rvOpE'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rvLegal = mainLegal & aluLegal & condLegal;

  always_comb begin
    mainLegal = 1'b1;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memSize   = 2'b00;
    memSigned = 1'b0;
    branch    = 2'b00;
    aluSrc    = 2'b00;
    immSrc    = IMM_I;
    resultSrc = RES_ALU;
    aluOp     = 2'b00;
    case (op)
      OP_LOAD: begin
        regWrite  = 1'b1;
        aluSrc    = 2'b01;
        resultSrc = RES_MEM;
        memSize   = funct3[1:0];
        memSigned = ~funct3[2]; // lbu/lhu zero extend
        mainLegal = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
      end
      OP_STORE: begin
        memWrite  = 1'b1;
        aluSrc    = 2'b01;
        immSrc    = IMM_S;
        memSize   = funct3[1:0];
        mainLegal = (funct3 <= 3'b010);
      end
      OP_OPREG: begin
        regWrite = 1'b1;
        aluOp    = 2'b10;
      end
      OP_OPIMM: begin
        regWrite = 1'b1;
        aluSrc   = 2'b01;
        aluOp    = 2'b10;
      end
      OP_BRANCH: begin
        immSrc = IMM_B;
        branch = 2'b01;
        aluOp  = 2'b01;
      end
      OP_JAL: begin
        regWrite  = 1'b1;
        immSrc    = IMM_J;
        aluSrc    = 2'b10; // pc + offset
        resultSrc = RES_PCPLUS4;
        branch    = 2'b01;
      end
      OP_JALR: begin
        regWrite  = 1'b1;
        aluSrc    = 2'b01;
        resultSrc = RES_PCPLUS4;
        branch    = 2'b10; // target from alu
        mainLegal = (funct3 == 3'b000);
      end
      OP_LUI: begin
        regWrite = 1'b1;
        immSrc   = IMM_U;
        aluSrc   = 2'b01;
        aluOp    = 2'b11;
      end
      OP_AUIPC: begin
        regWrite = 1'b1;
        immSrc   = IMM_U;
        aluSrc   = 2'b11;
      end
      default: mainLegal = 1'b0;
    endcase
  end

  always_comb begin
    aluLegal   = 1'b1;
    aluControl = ALU_ADD;
    case (aluOp)
      2'b01: aluControl = ALU_SUB;
      2'b11: aluControl = ALU_LUI;
      2'b10: begin
        case (funct3)
          3'b000: aluControl = (funct7[5] & instr[5]) ? ALU_SUB : ALU_ADD;
          3'b001: aluControl = ALU_SLL;
          3'b010: aluControl = ALU_SLT;
          3'b011: aluControl = ALU_SLT; // sltu shares the code
          3'b100: aluControl = ALU_XOR;
          3'b101: aluControl = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: aluControl = ALU_OR;
          default: aluControl = ALU_AND;
        endcase
        // funct7 only carries bit 5, and only for sub and sra
        if (op == OP_OPREG || funct3 == 3'b001 || funct3 == 3'b101) begin
          aluLegal = (funct7 == 7'b0000000) |
                     ((funct7 == 7'b0100000) & (funct3 == 3'b000 || funct3 == 3'b101));
        end
      end
      default: aluControl = ALU_ADD;
    endcase
  end

  // branch compare mapped onto A32 condition codes
  always_comb begin
    condLegal = 1'b1;
    cond      = COND_ALWAYS;
    if (op == OP_BRANCH) begin
      case (funct3)
        3'b000: cond = 4'b0000; // beq -> EQ
        3'b001: cond = 4'b0001; // bne -> NE
        3'b100: cond = 4'b1011; // blt -> LT
        3'b101: cond = 4'b1010; // bge -> GE
        3'b110: cond = 4'b0011; // bltu -> CC
        3'b111: cond = 4'b0010; // bgeu -> CS
        default: condLegal = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/armDecoder.sv
`default_nettype none

module armDecoder (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          accept,
  input  logic                          bubble,
  input  logic [decodePkg::INSTR_W-1:0] instr,
  output logic                          armLegal,
  output logic                          regWrite,
  output logic                          memWrite,
  output logic [1:0]                    memSize,
  output logic                          memSigned,
  output decodePkg::aluCtrlE            aluControl,
  output logic                          branch,
  output logic                          aluSrc,
  output decodePkg::immSrcE             immSrc,
  output logic                          resultSrc, // memory data to rd
  output logic [1:0]                    flagWrite,
  output logic [3:0]                    regSrc,
  output logic [4:0]                    shiftAmt,
  output logic [2:0]                    shiftType,
  output logic                          pcSrc,
  output logic                          stallF
);

  import decodePkg::*;

  armClassE   opClass;
  ldmPhaseE   ldmPhase;
  ldmPhaseE   ldmPhaseNext;
  aluCtrlE    dpAlu;
  aluCtrlE    addSub;   // offset direction from the U bit
  logic [3:0] dpOp;
  logic [1:0] dpShift;  // 00 none, 01 immediate shift, 10 rotated imm8
  logic       sBit;
  logic       isCompare;
  logic       mainLegal;

  assign opClass   = armClassE'(instr[27:25]);
  assign dpOp      = instr[24:21];
  assign sBit      = instr[20]; // also the L bit of transfers
  assign isCompare = (dpOp[3:2] == 2'b10);
  assign addSub    = instr[23] ? ALU_ADD : ALU_SUB;
  assign armLegal  = mainLegal & (instr[31:28] != COND_NEVER);

  always_comb begin
    case (dpOp)
      4'b0000, 4'b1000: dpAlu = ALU_AND; // and, tst
      4'b0001, 4'b1001: dpAlu = ALU_XOR; // eor, teq
      4'b0010, 4'b1010: dpAlu = ALU_SUB; // sub, cmp
      4'b0011:          dpAlu = ALU_RSB;
      4'b0100, 4'b1011: dpAlu = ALU_ADD; // add, cmn
      4'b0101:          dpAlu = ALU_ADC;
      4'b0110:          dpAlu = ALU_SBC;
      4'b0111:          dpAlu = ALU_RSC;
      4'b1100:          dpAlu = ALU_OR;
      4'b1101:          dpAlu = ALU_MOV;
      4'b1110:          dpAlu = ALU_BIC;
      default:          dpAlu = ALU_MVN;
    endcase
  end

  always_comb begin
    mainLegal  = 1'b1;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    memSize    = 2'b10;
    memSigned  = 1'b0;
    aluControl = ALU_ADD;
    branch     = 1'b0;
    aluSrc     = 1'b0;
    immSrc     = ARM_IMM8;
    resultSrc  = 1'b0;
    flagWrite  = 2'b00;
    regSrc     = 4'b0000;
    dpShift    = 2'b00;
    stallF     = 1'b0;
    case (opClass)
      CLS_DPREG, CLS_DPIMM: begin
        aluControl   = dpAlu;
        regWrite     = ~isCompare;
        aluSrc       = (opClass == CLS_DPIMM);
        dpShift      = (opClass == CLS_DPIMM) ? 2'b10 : 2'b01;
        flagWrite[1] = sBit;
        flagWrite[0] = sBit &
          (dpAlu inside {ALU_ADD, ALU_SUB, ALU_RSB, ALU_ADC, ALU_SBC, ALU_RSC});
        // compares without S are status moves, bit 4 set means register shift
        mainLegal    = ~(isCompare & ~sBit) & ~((opClass == CLS_DPREG) & instr[4]);
      end
      CLS_MEMIMM, CLS_MEMREG: begin
        regWrite   = sBit;
        memWrite   = ~sBit;
        resultSrc  = sBit;
        memSize    = instr[22] ? 2'b00 : 2'b10; // byte or word
        aluControl = addSub;
        aluSrc     = (opClass == CLS_MEMIMM);
        immSrc     = ARM_IMM12;
        regSrc     = {2'b00, ~sBit, 1'b0}; // store data from rd
        dpShift    = (opClass == CLS_MEMREG) ? 2'b01 : 2'b00;
        mainLegal  = ~((opClass == CLS_MEMREG) & instr[4]);
      end
      CLS_BRANCH: begin
        branch = 1'b1;
        aluSrc = 1'b1;
        immSrc = ARM_IMM24;
        regSrc = 4'b0001; // pc as first operand
      end
      CLS_BLOCK: begin
        aluSrc = 1'b1;
        immSrc = ARM_IMM12;
        if (ldmPhase == LDM_FIRST) begin
          regSrc     = 4'b0100;
          regWrite   = sBit;
          memWrite   = ~sBit;
          resultSrc  = 1'b1;
          aluControl = instr[24] ? addSub : ALU_PASSA; // pre-index moves first
          stallF     = 1'b1; // same word comes back for the second op
        end else begin
          regSrc     = 4'b1000;
          regWrite   = instr[21]; // base writeback
          aluControl = instr[24] ? ALU_PASSA : addSub;
        end
      end
      default: mainLegal = 1'b0;
    endcase
  end

  always_comb begin
    case (dpShift)
      2'b01: begin
        shiftAmt  = instr[11:7];
        shiftType = {1'b1, instr[6:5]};
      end
      2'b10: begin
        shiftAmt  = {instr[11:8], 1'b0};
        shiftType = 3'b111; // ror
      end
      default: begin
        shiftAmt  = 5'd0;
        shiftType = 3'b100;
      end
    endcase
  end

  assign pcSrc = (instr[15:12] == 4'hF) & regWrite;

  // phase returns to FIRST after any word other than a first LDM/STM
  always_comb begin
    ldmPhaseNext = LDM_FIRST;
    if (!bubble && armLegal && opClass == CLS_BLOCK && ldmPhase == LDM_FIRST) begin
      ldmPhaseNext = LDM_LAST;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ldmPhase <= LDM_FIRST;
    end else if (accept) begin
      ldmPhase <= ldmPhaseNext;
    end
  end

endmodule

`default_nettype wire

// File: verilog/isaMerge.sv
`default_nettype none

module isaMerge (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        accept,
  input  logic                        bubble,
  input  logic                        rvLegal,
  input  logic                        armLegal,
  input  logic                        rvRegWrite,
  input  logic                        rvMemWrite,
  input  logic [1:0]                  rvMemSize,
  input  logic                        rvMemSigned,
  input  decodePkg::aluCtrlE          rvAluControl,
  input  logic [1:0]                  rvBranch,
  input  logic [1:0]                  rvAluSrc,
  input  decodePkg::immSrcE           rvImmSrc,
  input  decodePkg::resultSrcE        rvResultSrc,
  input  logic [3:0]                  rvCond,
  input  logic [3:0]                  armCond,
  input  logic                        armRegWrite,
  input  logic                        armMemWrite,
  input  logic [1:0]                  armMemSize,
  input  logic                        armMemSigned,
  input  decodePkg::aluCtrlE          armAluControl,
  input  logic                        armBranch,
  input  logic                        armAluSrc,
  input  decodePkg::immSrcE           armImmSrc,
  input  logic                        armResultSrc,
  input  logic [1:0]                  armFlagWrite,
  input  logic [3:0]                  armRegSrc,
  input  logic [4:0]                  armShiftAmt,
  input  logic [2:0]                  armShiftType,
  input  logic                        armPcSrc,
  input  logic                        armStallF,
  output logic                        isArm,
  output logic                        illegal,
  output logic                        regWrite,
  output logic                        memWrite,
  output logic [1:0]                  memSize,
  output logic                        memSigned,
  output decodePkg::aluCtrlE          aluControl,
  output logic [1:0]                  branch,
  output logic [1:0]                  aluSrc,
  output decodePkg::immSrcE           immSrc,
  output logic [3:0]                  cond,
  output decodePkg::resultSrcE        resultSrc,
  output logic [1:0]                  flagWrite,
  output logic [3:0]                  regSrc,
  output logic [4:0]                  shiftAmt,
  output logic [2:0]                  shiftType,
  output logic                        pcSrc,
  output logic                        stallF
);

  import decodePkg::*;

  logic armMode; // 0 after reset, RV32I
  logic kill;

  // a word only one decoder accepts picks the ISA, anything else keeps the mode
  always_comb begin
    if (bubble) isArm = armMode;
    else if (armLegal && !rvLegal) isArm = 1'b1;
    else if (rvLegal && !armLegal) isArm = 1'b0;
    else isArm = armMode;
  end

  assign illegal = ~bubble & ~rvLegal & ~armLegal;
  assign kill    = bubble | illegal;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      armMode <= 1'b0;
    end else if (accept) begin
      armMode <= isArm;
    end
  end

  always_comb begin
    if (isArm) begin
      regWrite   = armRegWrite;
      memWrite   = armMemWrite;
      memSize    = armMemSize;
      memSigned  = armMemSigned;
      aluControl = armAluControl;
      branch     = {armBranch, 1'b0};
      aluSrc     = {1'b0, armAluSrc};
      immSrc     = armImmSrc;
      cond       = armCond;
      resultSrc  = armResultSrc ? RES_MEM : RES_ALU;
      flagWrite  = armFlagWrite;
      regSrc     = armRegSrc;
      shiftAmt   = armShiftAmt;
      shiftType  = armShiftType;
      pcSrc      = armPcSrc;
      stallF     = armStallF;
    end else begin
      regWrite   = rvRegWrite;
      memWrite   = rvMemWrite;
      memSize    = rvMemSize;
      memSigned  = rvMemSigned;
      aluControl = rvAluControl;
      branch     = rvBranch;
      aluSrc     = rvAluSrc;
      immSrc     = rvImmSrc;
      cond       = rvCond;
      resultSrc  = rvResultSrc;
      flagWrite  = 2'b00;
      regSrc     = 4'b0000;
      shiftAmt   = 5'd0;
      shiftType  = 3'b000;
      pcSrc      = 1'b0;
      stallF     = 1'b0;
    end
    if (kill) begin // nothing may retire from an empty or bad slot
      regWrite  = 1'b0;
      memWrite  = 1'b0;
      flagWrite = 2'b00;
      branch    = 2'b00;
      pcSrc     = 1'b0;
      stallF    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`default_nettype none

module decodeStage (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          req,
  input  logic [decodePkg::INSTR_W-1:0] instr,
  input  logic                          bubble,
  output logic                          ack,
  output logic                          isArm,
  output logic                          illegal,
  output logic                          regWrite,
  output logic                          memWrite,
  output logic [1:0]                    memSize,
  output logic                          memSigned,
  output decodePkg::aluCtrlE            aluControl,
  output logic [1:0]                    branch,
  output logic [1:0]                    aluSrc,
  output decodePkg::immSrcE             immSrc,
  output logic [3:0]                    cond,
  output decodePkg::resultSrcE          resultSrc,
  output logic [1:0]                    flagWrite,
  output logic [3:0]                    regSrc,
  output logic [4:0]                    shiftAmt,
  output logic [2:0]                    shiftType,
  output logic                          pcSrc,
  output logic                          stallF
);

  import decodePkg::*;

  hsStateE    state;
  logic       accept;
  logic       rvLegal, rvRegWrite, rvMemWrite, rvMemSigned;
  logic [1:0] rvMemSize, rvBranch, rvAluSrc;
  logic [3:0] rvCond;
  aluCtrlE    rvAluControl;
  immSrcE     rvImmSrc;
  resultSrcE  rvResultSrc;
  logic       armLegal, armRegWrite, armMemWrite, armMemSigned, armBranch, armAluSrc;
  logic       armResultSrc, armPcSrc, armStallF;
  logic [1:0] armMemSize, armFlagWrite;
  logic [3:0] armRegSrc;
  logic [4:0] armShiftAmt;
  logic [2:0] armShiftType;
  aluCtrlE    armAluControl;
  immSrcE     armImmSrc;
  logic       mIsArm, mIllegal, mRegWrite, mMemWrite, mMemSigned, mPcSrc, mStallF;
  logic [1:0] mMemSize, mBranch, mAluSrc, mFlagWrite;
  logic [3:0] mCond, mRegSrc;
  logic [4:0] mShiftAmt;
  logic [2:0] mShiftType;
  aluCtrlE    mAluControl;
  immSrcE     mImmSrc;
  resultSrcE  mResultSrc;

  // four-phase handshake, ack is high exactly while in HOLD
  assign accept = (state == HS_IDLE) & req;
  assign ack    = (state == HS_HOLD);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE: if (req) state <= HS_HOLD;
        HS_HOLD: if (!req) state <= HS_IDLE;
        default: state <= HS_IDLE;
      endcase
    end
  end

  rvDecoder rvDec0 (
    .instr, .rvLegal, .regWrite(rvRegWrite), .memWrite(rvMemWrite),
    .memSize(rvMemSize), .memSigned(rvMemSigned), .aluControl(rvAluControl),
    .branch(rvBranch), .aluSrc(rvAluSrc), .immSrc(rvImmSrc),
    .resultSrc(rvResultSrc), .cond(rvCond)
  );

  armDecoder armDec0 (
    .clk, .rstN, .accept, .bubble, .instr, .armLegal,
    .regWrite(armRegWrite), .memWrite(armMemWrite), .memSize(armMemSize),
    .memSigned(armMemSigned), .aluControl(armAluControl), .branch(armBranch),
    .aluSrc(armAluSrc), .immSrc(armImmSrc), .resultSrc(armResultSrc),
    .flagWrite(armFlagWrite), .regSrc(armRegSrc), .shiftAmt(armShiftAmt),
    .shiftType(armShiftType), .pcSrc(armPcSrc), .stallF(armStallF)
  );

  isaMerge merge0 (
    .clk, .rstN, .accept, .bubble, .rvLegal, .armLegal,
    .rvRegWrite, .rvMemWrite, .rvMemSize, .rvMemSigned, .rvAluControl,
    .rvBranch, .rvAluSrc, .rvImmSrc, .rvResultSrc, .rvCond,
    .armCond(instr[31:28]),
    .armRegWrite, .armMemWrite, .armMemSize, .armMemSigned, .armAluControl,
    .armBranch, .armAluSrc, .armImmSrc, .armResultSrc, .armFlagWrite,
    .armRegSrc, .armShiftAmt, .armShiftType, .armPcSrc, .armStallF,
    .isArm(mIsArm), .illegal(mIllegal), .regWrite(mRegWrite), .memWrite(mMemWrite),
    .memSize(mMemSize), .memSigned(mMemSigned), .aluControl(mAluControl),
    .branch(mBranch), .aluSrc(mAluSrc), .immSrc(mImmSrc), .cond(mCond),
    .resultSrc(mResultSrc), .flagWrite(mFlagWrite), .regSrc(mRegSrc),
    .shiftAmt(mShiftAmt), .shiftType(mShiftType), .pcSrc(mPcSrc), .stallF(mStallF)
  );

  // enables and mode, cleared by reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      isArm     <= 1'b0;
      illegal   <= 1'b0;
      regWrite  <= 1'b0;
      memWrite  <= 1'b0;
      branch    <= 2'b00;
      flagWrite <= 2'b00;
      pcSrc     <= 1'b0;
      stallF    <= 1'b0;
    end else if (accept) begin
      isArm     <= mIsArm;
      illegal   <= mIllegal;
      regWrite  <= mRegWrite;
      memWrite  <= mMemWrite;
      branch    <= mBranch;
      flagWrite <= mFlagWrite;
      pcSrc     <= mPcSrc;
      stallF    <= mStallF;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      memSize    <= mMemSize;
      memSigned  <= mMemSigned;
      aluControl <= mAluControl;
      aluSrc     <= mAluSrc;
      immSrc     <= mImmSrc;
      cond       <= mCond;
      resultSrc  <= mResultSrc;
      regSrc     <= mRegSrc;
      shiftAmt   <= mShiftAmt;
      shiftType  <= mShiftType;
    end
  end

endmodule

`default_nettype wire

// File: tb/decode_checker.sv
`default_nettype none

module decodeChecker (
  input logic        clk,
  input logic        rstN,
  input logic        req,
  input logic        ack,
  input logic [40:0] word // registered control word with isArm and illegal
);

  int failCount = 0;

  ackLowInReset: assert property (@(posedge clk) !rstN |-> !ack)
    else begin
      failCount++;
      $error("ack is high while reset is asserted");
    end

  // ack rises one edge after req is sampled high in IDLE
  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    $rose(ack) |-> $past(req))
    else begin
      failCount++;
      $error("ack rose without a request");
    end

  wordFrozen: assert property (@(posedge clk) disable iff (!rstN)
    (ack && $past(ack)) |-> $stable(word))
    else begin
      failCount++;
      $error("control word changed while ack was high");
    end

endmodule

bind decodeStage decodeChecker chk0 (
  .clk(clk),
  .rstN(rstN),
  .req(req),
  .ack(ack),
  .word({isArm, illegal, regWrite, memWrite, memSize, memSigned, aluControl, branch,
         aluSrc, immSrc, cond, resultSrc, flagWrite, regSrc, shiftAmt, shiftType,
         pcSrc, stallF})
);

`default_nettype wire

// File: tb/decodeMonitor.sv
`default_nettype none

module decodeMonitor (
  input  logic        clk,
  input  logic        rstN,
  input  logic        ack,
  input  logic        isArm,
  input  logic        illegal,
  input  logic        regWrite,
  input  logic        memWrite,
  input  logic [4:0]  aluControl,
  input  logic [3:0]  cond,
  input  logic [1:0]  flagWrite,
  input  logic        stallF,
  input  logic        pcSrc,
  input  logic [1:0]  branch,
  input  logic [1:0]  resultSrc,
  input  logic [3:0]  regSrc,
  input  logic [4:0]  shiftAmt,
  input  logic [2:0]  shiftType,
  input  logic [95:0] testName,
  input  logic        expBubble,
  input  logic        expIsArm,
  input  logic        expIllegal,
  input  logic        expRegWrite,
  input  logic        expMemWrite,
  input  logic [4:0]  expAluControl,
  input  logic [3:0]  expCond,
  input  logic [1:0]  expFlagWrite,
  input  logic        expStallF,
  input  logic        expPcSrc,
  output int          mismatches,
  output int          responses
);

  int   errorCount   = 0;
  int   ackCount     = 0;
  logic ackPrev      = 1'b0;
  logic resetChecked = 1'b0;

  assign mismatches = errorCount;
  assign responses  = ackCount;

  task automatic compareField(input logic [95:0] name, input string field,
                              input logic [31:0] expV, input logic [31:0] actV);
    if (actV !== expV) begin
      errorCount++;
      $display("CHECK FAILED %0s %0s: expected %0h actual %0h", name, field, expV, actV);
    end
  endtask

  // outputs are sampled one edge after ack rose, so they have settled
  always @(posedge clk) begin
    if (!rstN) begin
      ackPrev <= 1'b0;
    end else begin
      if (!resetChecked) begin
        resetChecked <= 1'b1;
        compareField("reset", "ack", 32'h0, 32'(ack));
        compareField("reset", "isArm", 32'h0, 32'(isArm));
        compareField("reset", "regWrite", 32'h0, 32'(regWrite));
        compareField("reset", "memWrite", 32'h0, 32'(memWrite));
        compareField("reset", "flagWrite", 32'h0, 32'(flagWrite));
        compareField("reset", "stallF", 32'h0, 32'(stallF));
        compareField("reset", "pcSrc", 32'h0, 32'(pcSrc));
      end
      if (ack && !ackPrev) begin
        ackCount++;
        compareField(testName, "isArm", 32'(expIsArm), 32'(isArm));
        compareField(testName, "illegal", 32'(expIllegal), 32'(illegal));
        compareField(testName, "regWrite", 32'(expRegWrite), 32'(regWrite));
        compareField(testName, "memWrite", 32'(expMemWrite), 32'(memWrite));
        compareField(testName, "aluControl", 32'(expAluControl), 32'(aluControl));
        compareField(testName, "cond", 32'(expCond), 32'(cond));
        compareField(testName, "flagWrite", 32'(expFlagWrite), 32'(flagWrite));
        compareField(testName, "stallF", 32'(expStallF), 32'(stallF));
        compareField(testName, "pcSrc", 32'(expPcSrc), 32'(pcSrc));
        if (expIllegal || expBubble) begin // empty or bad slot never branches
          compareField(testName, "branch", 32'h0, 32'(branch));
        end
        if (expIsArm) begin
          compareField(testName, "resultSrc[1]", 32'h0, 32'(resultSrc[1]));
        end else begin
          compareField(testName, "regSrc", 32'h0, 32'(regSrc));
          compareField(testName, "shiftAmt", 32'h0, 32'(shiftAmt));
          compareField(testName, "shiftType", 32'h0, 32'(shiftType));
        end
      end
      ackPrev <= ack;
    end
  end

endmodule

`default_nettype wire

// File: tb/decodeTb.sv
`default_nettype none

module decodeTb;

  import decodePkg::*;

  localparam int PERIOD     = 100;
  localparam int DRV        = 10;  // drive delay after the rising edge
  localparam int RST_CYCLES = 16;
  localparam int NUM_ROWS   = 26;

  typedef struct packed {
    logic [95:0] name;
    logic [31:0] instr;
    logic        bubble;
    logic        isArm;
    logic        illegal;
    logic        regWrite;
    logic        memWrite;
    logic        stallF;
    logic        pcSrc;
    aluCtrlE     alu;
    logic [3:0]  cond;
    logic [1:0]  flagWrite;
    int          hold;      // extra cycles req stays high after ack
  } rowT;

  rowT        rows [NUM_ROWS];
  rowT        cur;
  int         nRows = 0;
  logic       clk;
  logic       rstN;
  logic       req;
  logic       bubble;
  logic [31:0] instr;
  logic       ack, isArm, illegal, regWrite, memWrite, memSigned, pcSrc, stallF;
  logic [1:0] memSize, branch, aluSrc, flagWrite;
  logic [3:0] cond, regSrc;
  logic [4:0] shiftAmt;
  logic [2:0] shiftType;
  aluCtrlE    aluControl;
  immSrcE     immSrc;
  resultSrcE  resultSrc;
  int         mismatches;
  int         responses;

  decodeStage dut0 (
    .clk, .rstN, .req, .instr, .bubble, .ack, .isArm, .illegal, .regWrite,
    .memWrite, .memSize, .memSigned, .aluControl, .branch, .aluSrc, .immSrc,
    .cond, .resultSrc, .flagWrite, .regSrc, .shiftAmt, .shiftType, .pcSrc, .stallF
  );

  decodeMonitor mon0 (
    .clk, .rstN, .ack, .isArm, .illegal, .regWrite, .memWrite, .aluControl,
    .cond, .flagWrite, .stallF, .pcSrc, .branch, .resultSrc, .regSrc,
    .shiftAmt, .shiftType, .testName(cur.name), .expBubble(cur.bubble),
    .expIsArm(cur.isArm), .expIllegal(cur.illegal), .expRegWrite(cur.regWrite),
    .expMemWrite(cur.memWrite), .expAluControl(cur.alu), .expCond(cur.cond),
    .expFlagWrite(cur.flagWrite), .expStallF(cur.stallF), .expPcSrc(cur.pcSrc),
    .mismatches, .responses
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // flags are {bubble, isArm, illegal, regWrite, memWrite, stallF, pcSrc}
  task automatic addRow(input logic [95:0] name, input logic [31:0] word,
                        input logic [6:0] flags, input aluCtrlE alu,
                        input logic [3:0] cnd, input logic [1:0] fw, input int hold);
    if (nRows < NUM_ROWS) begin
      rows[nRows].name  = name;
      rows[nRows].instr = word;
      {rows[nRows].bubble, rows[nRows].isArm, rows[nRows].illegal, rows[nRows].regWrite,
       rows[nRows].memWrite, rows[nRows].stallF, rows[nRows].pcSrc} = flags;
      rows[nRows].alu       = alu;
      rows[nRows].cond      = cnd;
      rows[nRows].flagWrite = fw;
      rows[nRows].hold      = hold;
    end
    nRows++;
  endtask

  task automatic buildTable();
    addRow("add", 32'h003100B3, 7'b0_0_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("sub", 32'h40628233, 7'b0_0_0_1_0_0_0, ALU_SUB, COND_ALWAYS, 2'b00, 0);
    addRow("sra", 32'h409453B3, 7'b0_0_0_1_0_0_0, ALU_SRA, COND_ALWAYS, 2'b00, 0);
    addRow("lw", 32'h0085A503, 7'b0_0_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("lhu", 32'h0026D603, 7'b0_0_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("sw", 32'h00E7A623, 7'b0_0_0_0_1_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("beq", 32'h00208863, 7'b0_0_0_0_0_0_0, ALU_SUB, 4'h0, 2'b00, 0); // EQ
    addRow("bltu", 32'h0041E463, 7'b0_0_0_0_0_0_0, ALU_SUB, 4'h3, 2'b00, 0); // CC
    addRow("jal", 32'h020000EF, 7'b0_0_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("lui", 32'h123452B7, 7'b0_0_0_1_0_0_0, ALU_LUI, COND_ALWAYS, 2'b00, 0);
    addRow("adds", 32'hE0921004, 7'b0_1_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b11, 0);
    addRow("bothKeep", 32'hE0921003, 7'b0_1_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b11, 0);
    addRow("cmp", 32'hE1510002, 7'b0_1_0_0_0_0_0, ALU_SUB, COND_ALWAYS, 2'b11, 0);
    addRow("movPc", 32'hE1A0F00E, 7'b0_1_0_1_0_0_1, ALU_MOV, COND_ALWAYS, 2'b00, 0);
    addRow("eorNe", 32'h10243005, 7'b0_1_0_1_0_0_0, ALU_XOR, 4'h1, 2'b00, 0);
    addRow("rvBack", 32'h003100B3, 7'b0_0_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    // ldmia r0!, {r1,r2} then stmia r1, {r2}, each word presented twice
    // first ldm held, a second decode there would move the phase on
    addRow("ldmFirst", 32'hE8B00006, 7'b0_1_0_1_0_1_0, ALU_PASSA, COND_ALWAYS, 2'b00, 5);
    addRow("ldmLast", 32'hE8B00006, 7'b0_1_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("stmFirst", 32'hE8810004, 7'b0_1_0_0_1_1_0, ALU_PASSA, COND_ALWAYS, 2'b00, 0);
    addRow("stmLast", 32'hE8810004, 7'b0_1_0_0_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("ldmCut", 32'hE8B00006, 7'b0_1_0_1_0_1_0, ALU_PASSA, COND_ALWAYS, 2'b00, 0);
    addRow("bubble", 32'h00000000, 7'b1_1_0_0_0_0_0, ALU_AND, 4'h0, 2'b00, 0);
    addRow("ldmRestart", 32'hE8B00006, 7'b0_1_0_1_0_1_0, ALU_PASSA, COND_ALWAYS, 2'b00, 0);
    addRow("ldmEnd", 32'hE8B00006, 7'b0_1_0_1_0_0_0, ALU_ADD, COND_ALWAYS, 2'b00, 0);
    addRow("badBoth", 32'hFFFFFFFF, 7'b0_1_1_0_0_0_0, ALU_ADD, 4'hF, 2'b00, 0);
    addRow("rvAfterBad", 32'h40628233, 7'b0_0_0_1_0_0_0, ALU_SUB, COND_ALWAYS, 2'b00, 0);
  endtask

  // one four-phase transaction
  task automatic runRow(input rowT r);
    @(posedge clk);
    #DRV;
    cur    = r;
    instr  = r.instr;
    bubble = r.bubble;
    req    = 1'b1;
    do begin
      @(posedge clk);
      #DRV;
    end while (!ack);
    if (r.hold > 0) begin
      repeat (r.hold) @(posedge clk);
      #DRV;
    end
    req = 1'b0;
    while (ack) begin
      @(posedge clk);
      #DRV;
    end
  endtask

  initial begin
    #((NUM_ROWS * 10 + RST_CYCLES) * PERIOD);
    $display("watchdog expired before all rows were applied");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int   i;
    int   assertFails;
    logic failed;
    rstN   = 1'b0;
    req    = 1'b0;
    bubble = 1'b0;
    instr  = 32'h0;
    cur    = '0;
    void'($urandom(32'h6710));
    buildTable();
    repeat (RST_CYCLES) @(posedge clk);
    #DRV rstN = 1'b1;
    for (i = 0; i < NUM_ROWS; i++) begin
      repeat ($urandom % 4) @(posedge clk); // idle gap
      runRow(rows[i]);
    end
    repeat (2) @(posedge clk);
    assertFails = dut0.chk0.failCount;
    failed = (mismatches != 0) || (assertFails != 0) || (responses != NUM_ROWS) ||
             (nRows != NUM_ROWS);
    if (responses != NUM_ROWS) begin
      $display("monitor saw %0d responses but %0d rows were sent", responses, NUM_ROWS);
    end
    if (nRows != NUM_ROWS) begin
      $display("stimulus table holds %0d rows instead of %0d", nRows, NUM_ROWS);
    end
    $display("rows %0d, mismatches %0d, assertion failures %0d",
             responses, mismatches, assertFails);
    if (failed) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
verilog/decodePkg.sv
verilog/rvDecoder.sv
verilog/armDecoder.sv
verilog/isaMerge.sv
verilog/decodeStage.sv
tb/decode_checker.sv
tb/decodeMonitor.sv
tb/decodeTb.sv

// File: Makefile
TOP = decodeTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "TB PASSED" > /dev/null

clean:
	rm -rf obj_dir
